// ==== design/backend_pkg.sv ====
`default_nettype none

package backend_pkg;

    localparam int PRF_BITS = 6;  // physical register index
    localparam int ARF_BITS = 5;  // architectural register index
    localparam int XLEN     = 32;

    //////////////////////////////
    // rob slot
    typedef struct packed {
        logic                valid;
        logic                ready;
        logic [PRF_BITS-1:0] rd_phy;
        logic [ARF_BITS-1:0] rd_arch;
    } rob_entry_t;

    //////////////////////////////
    // one branch per rob row
    typedef struct packed {
        logic            valid;
        logic            mispredict;
        logic [XLEN-1:0] target;
    } branch_rec_t;

endpackage

`default_nettype wire

// ==== design/backend_ifs.sv ====
`default_nettype none

// head row of the rob, leaving toward the architectural state
interface commit_if #(
    parameter int ID_WIDTH = 2
) ();

    logic                                          retire;  // whole row leaves
    logic [ID_WIDTH-1:0]                           valid;
    logic [ID_WIDTH-1:0][backend_pkg::PRF_BITS-1:0] rd_phy;
    logic [ID_WIDTH-1:0][backend_pkg::ARF_BITS-1:0] rd_arch;

    modport source (
        output retire,
        output valid,
        output rd_phy,
        output rd_arch
    );

    modport sink (
        input retire,
        input valid,
        input rd_phy,
        input rd_arch
    );

endinterface

// rob asks the branch table about its head row
interface branch_if #(
    parameter int ROB_DEPTH = 8
) ();

    localparam int ROW_BITS = $clog2(ROB_DEPTH);

    logic [ROW_BITS-1:0]          head_row;
    logic                         retire;
    logic                         mispredict;
    logic [backend_pkg::XLEN-1:0] target;

    modport rob (
        output head_row,
        output retire,
        input  mispredict,
        input  target
    );

    modport tbl (
        input  head_row,
        input  retire,
        output mispredict,
        output target
    );

endinterface

`default_nettype wire

// ==== design/rob.sv ====
`default_nettype none

module rob #(
    parameter int ROB_DEPTH = 8,
    parameter int ID_WIDTH  = 2,
    parameter int CDB_WIDTH = 2,
    localparam int ROB_ID_BITS = $clog2(ROB_DEPTH * ID_WIDTH)
) (
    input  wire                                           clk,
    input  wire                                           rst_n,
    output logic                                          flush,
    input  wire                                           dispatch_valid,
    input  wire [ID_WIDTH-1:0]                            dispatch_slot_valid,
    input  wire [ID_WIDTH-1:0][backend_pkg::PRF_BITS-1:0] dispatch_rd_phy,
    input  wire [ID_WIDTH-1:0][backend_pkg::ARF_BITS-1:0] dispatch_rd_arch,
    output logic                                          dispatch_ready,
    output logic [ID_WIDTH-1:0][ROB_ID_BITS-1:0]          dispatch_rob_id,
    input  wire                                           accept_en,
    input  wire [CDB_WIDTH-1:0]                           cdb_valid,
    input  wire [CDB_WIDTH-1:0][ROB_ID_BITS-1:0]          cdb_rob_id,
    commit_if.source                                      commit,
    branch_if.rob                                         branch
);

    localparam int ROW_BITS  = $clog2(ROB_DEPTH);
    localparam int SLOT_BITS = (ID_WIDTH > 1) ? $clog2(ID_WIDTH) : 1;

    backend_pkg::rob_entry_t rob_arr [ROB_DEPTH][ID_WIDTH];

    logic [ROW_BITS:0]    head_q;  // msb is the wrap bit
    logic [ROW_BITS:0]    tail_q;
    logic [ROW_BITS-1:0]  head_row;
    logic [ROW_BITS-1:0]  tail_row;
    logic                 full;
    logic                 empty;
    logic                 retire;
    logic                 take;
    logic [ROW_BITS-1:0]  cdb_row  [CDB_WIDTH];
    logic [SLOT_BITS-1:0] cdb_slot [CDB_WIDTH];

    assign head_row = head_q[ROW_BITS-1:0];
    assign tail_row = tail_q[ROW_BITS-1:0];
    assign empty    = (head_q == tail_q);
    assign full     = (head_row == tail_row) && (head_q[ROW_BITS] != tail_q[ROW_BITS]);

    // head leaves once every live slot has completed
    always_comb begin
        retire = ~empty;
        for (int s = 0; s < ID_WIDTH; s++) begin
            if (rob_arr[head_row][s].valid && !rob_arr[head_row][s].ready) begin
                retire = 1'b0;
            end
        end
    end

    assign flush          = retire && branch.mispredict;
    assign dispatch_ready = ~full && accept_en && ~flush;  // no intake on the wrong path
    assign take           = dispatch_valid && dispatch_ready;

    always_comb begin
        for (int s = 0; s < ID_WIDTH; s++) begin
            dispatch_rob_id[s] = ROB_ID_BITS'(tail_row) * ROB_ID_BITS'(ID_WIDTH)
                               + ROB_ID_BITS'(s);
        end
    end

    for (genvar k = 0; k < CDB_WIDTH; k++) begin : g_cdb
        assign cdb_row[k]  = ROW_BITS'(cdb_rob_id[k] / ID_WIDTH);
        assign cdb_slot[k] = SLOT_BITS'(cdb_rob_id[k] % ID_WIDTH);
    end

    //////////////////////////////
    // row storage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q <= '0;
            tail_q <= '0;
            for (int r = 0; r < ROB_DEPTH; r++) begin
                for (int s = 0; s < ID_WIDTH; s++) begin
                    rob_arr[r][s].valid <= 1'b0;
                    rob_arr[r][s].ready <= 1'b0;
                end
            end
        end else if (flush) begin
            head_q <= '0;
            tail_q <= '0;
            for (int r = 0; r < ROB_DEPTH; r++) begin
                for (int s = 0; s < ID_WIDTH; s++) begin
                    rob_arr[r][s].valid <= 1'b0;
                    rob_arr[r][s].ready <= 1'b0;
                end
            end
        end else begin
            if (retire) begin
                head_q <= head_q + 1'b1;
                for (int s = 0; s < ID_WIDTH; s++) begin
                    rob_arr[head_row][s].valid <= 1'b0;
                    rob_arr[head_row][s].ready <= 1'b0;
                end
            end
            if (take) begin
                tail_q <= tail_q + 1'b1;
                for (int s = 0; s < ID_WIDTH; s++) begin
                    rob_arr[tail_row][s].valid   <= dispatch_slot_valid[s];
                    rob_arr[tail_row][s].ready   <= 1'b0;
                    rob_arr[tail_row][s].rd_phy  <= dispatch_rd_phy[s];
                    rob_arr[tail_row][s].rd_arch <= dispatch_rd_arch[s];
                end
            end
            // completions to dead slots drop out here
            for (int k = 0; k < CDB_WIDTH; k++) begin
                if (cdb_valid[k] && rob_arr[cdb_row[k]][cdb_slot[k]].valid) begin
                    rob_arr[cdb_row[k]][cdb_slot[k]].ready <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // commit side
    always_comb begin
        commit.retire = retire;
        for (int s = 0; s < ID_WIDTH; s++) begin
            commit.valid[s]   = retire && rob_arr[head_row][s].valid;
            commit.rd_phy[s]  = rob_arr[head_row][s].rd_phy;
            commit.rd_arch[s] = rob_arr[head_row][s].rd_arch;
        end
    end

    assign branch.head_row = head_row;
    assign branch.retire   = retire;

endmodule

`default_nettype wire

// ==== design/branch_table.sv ====
`default_nettype none

module branch_table #(
    parameter int ROB_DEPTH = 8,
    parameter int ID_WIDTH  = 2,
    localparam int ROB_ID_BITS = $clog2(ROB_DEPTH * ID_WIDTH)
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         flush,
    input  wire                         br_valid,
    input  wire [ROB_ID_BITS-1:0]       br_rob_id,
    input  wire                         br_mispredict,
    input  wire [backend_pkg::XLEN-1:0] br_target,
    branch_if.tbl                       branch
);

    localparam int ROW_BITS = $clog2(ROB_DEPTH);

    backend_pkg::branch_rec_t recs [ROB_DEPTH];

    logic [ROW_BITS-1:0] br_row;

    assign br_row = ROW_BITS'(br_rob_id / ID_WIDTH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < ROB_DEPTH; r++) begin
                recs[r].valid      <= 1'b0;
                recs[r].mispredict <= 1'b0;
            end
        end else if (flush) begin
            for (int r = 0; r < ROB_DEPTH; r++) begin
                recs[r].valid      <= 1'b0;
                recs[r].mispredict <= 1'b0;
            end
        end else begin
            if (branch.retire) begin
                recs[branch.head_row].valid      <= 1'b0;
                recs[branch.head_row].mispredict <= 1'b0;
            end
            if (br_valid) begin  // resolve wins over a same-row clear
                recs[br_row] <= '{valid: 1'b1, mispredict: br_mispredict, target: br_target};
            end
        end
    end

    assign branch.mispredict = recs[branch.head_row].valid && recs[branch.head_row].mispredict;
    assign branch.target     = recs[branch.head_row].target;

endmodule

`default_nettype wire

// ==== design/retire_rat.sv ====
`default_nettype none

module retire_rat #(
    parameter int ID_WIDTH = 2
) (
    input  wire                                            clk,
    input  wire                                            rst_n,
    commit_if.sink                                         commit,
    output logic [ID_WIDTH-1:0][backend_pkg::PRF_BITS-1:0] freed_phy
);

    localparam int PHY_W    = backend_pkg::PRF_BITS;
    localparam int ARF_REGS = 2 ** backend_pkg::ARF_BITS;

    logic [PHY_W-1:0] arch_map [ARF_REGS];

    // previous mapping, seen through older slots of the same row
    always_comb begin
        for (int i = 0; i < ID_WIDTH; i++) begin
            freed_phy[i] = arch_map[commit.rd_arch[i]];
            for (int j = 0; j < i; j++) begin
                if (commit.valid[j] && (commit.rd_arch[j] == commit.rd_arch[i])) begin
                    freed_phy[i] = commit.rd_phy[j];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < ARF_REGS; r++) begin
                arch_map[r] <= PHY_W'(r);  // identity map
            end
        end else if (commit.retire) begin
            for (int i = 0; i < ID_WIDTH; i++) begin
                if (commit.valid[i]) begin
                    arch_map[commit.rd_arch[i]] <= commit.rd_phy[i];  // youngest lands last
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/retire_counter.sv ====
`default_nettype none

module retire_counter #(
    parameter int ID_WIDTH = 2
) (
    input  wire                          clk,
    input  wire                          rst_n,
    commit_if.sink                       commit,
    output logic [ID_WIDTH-1:0][63:0]    order
);

    logic [63:0] count_q;
    logic [63:0] row_cnt;  // live slots in the head row

    always_comb begin
        row_cnt = '0;
        for (int i = 0; i < ID_WIDTH; i++) begin
            order[i] = count_q + row_cnt;
            if (commit.valid[i]) begin
                row_cnt = row_cnt + 64'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (commit.retire) begin
            count_q <= count_q + row_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== design/redirect_fsm.sv ====
`default_nettype none

module redirect_fsm (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          flush,
    input  wire [backend_pkg::XLEN-1:0]  flush_pc,
    output logic                         redirect_valid,
    output logic [backend_pkg::XLEN-1:0] redirect_pc,
    output logic                         accept_en,
    input  wire                          redirect_ready
);

    typedef enum logic {
        RUN,
        REDIRECT
    } state_t;

    state_t state_q;
    state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RUN:      if (flush)          state_d = REDIRECT;
            REDIRECT: if (redirect_ready) state_d = RUN;
            default:                      state_d = RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // target held for the whole request
    always_ff @(posedge clk) begin
        if ((state_q == RUN) && flush) begin
            redirect_pc <= flush_pc;
        end
    end

    assign redirect_valid = (state_q == REDIRECT);
    assign accept_en      = (state_q == RUN);

endmodule

`default_nettype wire

// ==== design/rob_commit_top.sv ====
`default_nettype none

module rob_commit_top #(
    parameter int ROB_DEPTH = 8,
    parameter int ID_WIDTH  = 2,
    parameter int CDB_WIDTH = 2,
    localparam int ROB_ID_BITS = $clog2(ROB_DEPTH * ID_WIDTH)
) (
    input  wire                                            clk,
    input  wire                                            rst_n,
    // dispatch
    input  wire                                            dispatch_valid,
    input  wire [ID_WIDTH-1:0]                             dispatch_slot_valid,
    input  wire [ID_WIDTH-1:0][backend_pkg::PRF_BITS-1:0]  dispatch_rd_phy,
    input  wire [ID_WIDTH-1:0][backend_pkg::ARF_BITS-1:0]  dispatch_rd_arch,
    output logic                                           dispatch_ready,
    output logic [ID_WIDTH-1:0][ROB_ID_BITS-1:0]           dispatch_rob_id,
    // completion
    input  wire [CDB_WIDTH-1:0]                            cdb_valid,
    input  wire [CDB_WIDTH-1:0][ROB_ID_BITS-1:0]           cdb_rob_id,
    // branch resolve
    input  wire                                            br_valid,
    input  wire [ROB_ID_BITS-1:0]                          br_rob_id,
    input  wire                                            br_mispredict,
    input  wire [backend_pkg::XLEN-1:0]                    br_target,
    // commit
    output logic [ID_WIDTH-1:0]                            commit_valid,
    output logic [ID_WIDTH-1:0][backend_pkg::ARF_BITS-1:0] commit_rd_arch,
    output logic [ID_WIDTH-1:0][backend_pkg::PRF_BITS-1:0] commit_rd_phy,
    output logic [ID_WIDTH-1:0][63:0]                      commit_order,
    output logic [ID_WIDTH-1:0][backend_pkg::PRF_BITS-1:0] commit_freed_phy,
    // front end redirect
    output logic                                           redirect_valid,
    output logic [backend_pkg::XLEN-1:0]                   redirect_pc,
    input  wire                                            redirect_ready
);

    logic flush;
    logic accept_en;

    commit_if #(.ID_WIDTH(ID_WIDTH))  u_commit_bus ();
    branch_if #(.ROB_DEPTH(ROB_DEPTH)) u_branch_bus ();

    rob #(
        .ROB_DEPTH (ROB_DEPTH),
        .ID_WIDTH  (ID_WIDTH),
        .CDB_WIDTH (CDB_WIDTH)
    ) u_rob (
        .clk                 (clk),
        .rst_n               (rst_n),
        .flush               (flush),
        .dispatch_valid      (dispatch_valid),
        .dispatch_slot_valid (dispatch_slot_valid),
        .dispatch_rd_phy     (dispatch_rd_phy),
        .dispatch_rd_arch    (dispatch_rd_arch),
        .dispatch_ready      (dispatch_ready),
        .dispatch_rob_id     (dispatch_rob_id),
        .accept_en           (accept_en),
        .cdb_valid           (cdb_valid),
        .cdb_rob_id          (cdb_rob_id),
        .commit              (u_commit_bus.source),
        .branch              (u_branch_bus.rob)
    );

    branch_table #(
        .ROB_DEPTH (ROB_DEPTH),
        .ID_WIDTH  (ID_WIDTH)
    ) u_branch_table (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .br_valid      (br_valid),
        .br_rob_id     (br_rob_id),
        .br_mispredict (br_mispredict),
        .br_target     (br_target),
        .branch        (u_branch_bus.tbl)
    );

    retire_rat #(.ID_WIDTH(ID_WIDTH)) u_retire_rat (
        .clk       (clk),
        .rst_n     (rst_n),
        .commit    (u_commit_bus.sink),
        .freed_phy (commit_freed_phy)
    );

    retire_counter #(.ID_WIDTH(ID_WIDTH)) u_retire_counter (
        .clk    (clk),
        .rst_n  (rst_n),
        .commit (u_commit_bus.sink),
        .order  (commit_order)
    );

    redirect_fsm u_redirect_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .flush_pc       (u_branch_bus.target),  // head row target
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .accept_en      (accept_en),
        .redirect_ready (redirect_ready)
    );

    assign commit_valid   = u_commit_bus.valid;
    assign commit_rd_arch = u_commit_bus.rd_arch;
    assign commit_rd_phy  = u_commit_bus.rd_phy;

endmodule

`default_nettype wire

// ==== verif/tb_rob_commit_properties.sv ====
`default_nettype none

module tb_rob_commit_properties #(
    parameter int ID_WIDTH = 2
) (
    input wire                         clk,
    input wire                         rst_n,
    input wire                         flush,
    input wire                         dispatch_ready,
    input wire [ID_WIDTH-1:0]          commit_valid,
    input wire                         redirect_valid,
    input wire                         redirect_ready,
    input wire [backend_pkg::XLEN-1:0] redirect_pc
);

    // pending request keeps its pc
    a_pc_held: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid && !redirect_ready |=> redirect_valid && $stable(redirect_pc))
        else $error("redirect request dropped or its pc moved before redirect_ready");

    a_no_dispatch: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |-> !dispatch_ready)  // front end is on the wrong path
        else $error("dispatch_ready high while a redirect is pending");

    a_quiet_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> (commit_valid == '0))
        else $error("commit in the cycle after a flush");

endmodule

// redirect handshake and flush window of the commit block
bind rob_commit_top tb_rob_commit_properties #(.ID_WIDTH(ID_WIDTH)) u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .dispatch_ready (dispatch_ready),
    .commit_valid   (commit_valid),
    .redirect_valid (redirect_valid),
    .redirect_ready (redirect_ready),
    .redirect_pc    (redirect_pc)
);

`default_nettype wire

// ==== verif/tb_rob_commit.sv ====
`default_nettype none

module tb_rob_commit;

    localparam int          ROB_DEPTH   = 8;
    localparam int          ID_WIDTH    = 2;
    localparam int          CDB_WIDTH   = 2;
    localparam int          ROB_ID_BITS = $clog2(ROB_DEPTH * ID_WIDTH);
    localparam int          PRF_W       = backend_pkg::PRF_BITS;
    localparam int          ARF_W       = backend_pkg::ARF_BITS;
    localparam int          XLEN        = backend_pkg::XLEN;
    localparam int          N_ROWS      = 400;
    localparam logic [31:0] SEED        = 32'h3c51_d75f;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  dispatch_valid;
    logic [ID_WIDTH-1:0]                   dispatch_slot_valid;
    logic [ID_WIDTH-1:0][PRF_W-1:0]        dispatch_rd_phy;
    logic [ID_WIDTH-1:0][ARF_W-1:0]        dispatch_rd_arch;
    logic                                  dispatch_ready;
    logic [ID_WIDTH-1:0][ROB_ID_BITS-1:0]  dispatch_rob_id;
    logic [CDB_WIDTH-1:0]                  cdb_valid;
    logic [CDB_WIDTH-1:0][ROB_ID_BITS-1:0] cdb_rob_id;
    logic                                  br_valid;
    logic [ROB_ID_BITS-1:0]                br_rob_id;
    logic                                  br_mispredict;
    logic [XLEN-1:0]                       br_target;
    logic [ID_WIDTH-1:0]                   commit_valid;
    logic [ID_WIDTH-1:0][ARF_W-1:0]        commit_rd_arch;
    logic [ID_WIDTH-1:0][PRF_W-1:0]        commit_rd_phy;
    logic [ID_WIDTH-1:0][63:0]             commit_order;
    logic [ID_WIDTH-1:0][PRF_W-1:0]        commit_freed_phy;
    logic                                  redirect_valid;
    logic [XLEN-1:0]                       redirect_pc;
    logic                                  redirect_ready;

    //////////////////////////////
    // reference model
    int              rows_q [$];  // rob rows in program order
    int              m_tail;
    int              rows_taken;
    logic            m_slot [ROB_DEPTH][ID_WIDTH];
    logic            m_done [ROB_DEPTH][ID_WIDTH];  // ready inside the rob
    logic            m_sent [ROB_DEPTH][ID_WIDTH];  // completion already on a cdb
    logic [PRF_W-1:0] m_phy [ROB_DEPTH][ID_WIDTH];
    logic [ARF_W-1:0] m_arch [ROB_DEPTH][ID_WIDTH];
    int              m_br_slot [ROB_DEPTH];
    logic            m_mis [ROB_DEPTH];
    logic [XLEN-1:0] m_tgt [ROB_DEPTH];
    logic            m_br_seen [ROB_DEPTH];  // resolve landed in the table
    logic [PRF_W-1:0] m_map [2**ARF_W];
    logic [63:0]     m_order;
    logic            m_redir;
    logic [XLEN-1:0] m_pc;
    int              row_br_slot;  // branch info of the row on the dispatch port
    logic            row_mis;
    logic [XLEN-1:0] row_tgt;

    rob_commit_top #(
        .ROB_DEPTH (ROB_DEPTH),
        .ID_WIDTH  (ID_WIDTH),
        .CDB_WIDTH (CDB_WIDTH)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input logic [63:0] got, input logic [63:0] want,
                               input string what);
        if (got !== want) begin
            $display("FAILED at time %0t: %s is %0h, expected %0h", $time, what, got, want);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // compare one cycle's outputs, then apply the coming clock edge to the model
    task automatic model_edge();
        int                  h;
        int                  r;
        int                  s;
        int                  k;
        bit                  retire_exp;
        bit                  flush_exp;
        bit                  ready_exp;
        logic [ID_WIDTH-1:0] cv_exp;

        h = 0;
        retire_exp = 1'b0;
        flush_exp  = 1'b0;
        cv_exp     = '0;
        if (rows_q.size() > 0) begin
            h = rows_q[0];
            retire_exp = 1'b1;
            for (s = 0; s < ID_WIDTH; s++) begin
                if (m_slot[h][s] && !m_done[h][s]) begin
                    retire_exp = 1'b0;
                end
            end
            flush_exp = retire_exp && m_br_seen[h] && m_mis[h];
        end
        ready_exp = (rows_q.size() < ROB_DEPTH) && !m_redir && !flush_exp;
        check_value(64'(dispatch_ready), 64'(ready_exp), "dispatch_ready");
        for (s = 0; s < ID_WIDTH; s++) begin
            check_value(64'(dispatch_rob_id[s]), 64'(m_tail * ID_WIDTH + s), "dispatch_rob_id");
        end
        check_value(64'(redirect_valid), 64'(m_redir), "redirect_valid");
        if (m_redir) begin
            check_value(64'(redirect_pc), 64'(m_pc), "redirect_pc");
        end
        if (retire_exp) begin
            for (s = 0; s < ID_WIDTH; s++) begin
                cv_exp[s] = m_slot[h][s];
            end
        end
        check_value(64'(commit_valid), 64'(cv_exp), "commit_valid");
        for (s = 0; s < ID_WIDTH; s++) begin
            if (cv_exp[s]) begin
                check_value(64'(commit_rd_arch[s]), 64'(m_arch[h][s]), "commit_rd_arch");
                check_value(64'(commit_rd_phy[s]), 64'(m_phy[h][s]), "commit_rd_phy");
                check_value(64'(commit_freed_phy[s]), 64'(m_map[m_arch[h][s]]), "commit_freed_phy");
                check_value(commit_order[s], m_order, "commit_order");
                m_map[m_arch[h][s]] = m_phy[h][s];  // next slot sees this mapping
                m_order = m_order + 64'd1;
            end
        end

        if (m_redir && redirect_ready) begin
            m_redir = 1'b0;
        end
        if (flush_exp) begin
            m_redir = 1'b1;
            m_pc    = m_tgt[h];
            rows_q.delete();
            m_tail  = 0;
            for (r = 0; r < ROB_DEPTH; r++) begin
                m_br_seen[r] = 1'b0;
            end
        end else begin
            if (retire_exp) begin
                void'(rows_q.pop_front());
                m_br_seen[h] = 1'b0;
            end
            if (dispatch_valid && ready_exp) begin
                r = m_tail;
                for (s = 0; s < ID_WIDTH; s++) begin
                    m_slot[r][s] = dispatch_slot_valid[s];
                    m_phy[r][s]  = dispatch_rd_phy[s];
                    m_arch[r][s] = dispatch_rd_arch[s];
                    m_done[r][s] = 1'b0;
                    m_sent[r][s] = 1'b0;
                end
                m_br_slot[r] = row_br_slot;
                m_mis[r]     = row_mis;
                m_tgt[r]     = row_tgt;
                m_br_seen[r] = 1'b0;
                rows_q.push_back(r);
                m_tail     = (m_tail + 1) % ROB_DEPTH;
                rows_taken = rows_taken + 1;
            end
            for (k = 0; k < CDB_WIDTH; k++) begin
                if (cdb_valid[k]) begin
                    m_done[int'(cdb_rob_id[k]) / ID_WIDTH][int'(cdb_rob_id[k]) % ID_WIDTH] = 1'b1;
                end
            end
            if (br_valid) begin
                m_br_seen[int'(br_rob_id) / ID_WIDTH] = 1'b1;
            end
        end
    endtask

    // random dispatch row, out-of-order completions and redirect_ready
    task automatic drive_inputs();
        int                                    cands [$];
        int                                    i;
        int                                    j;
        int                                    k;
        int                                    id;
        int                                    r;
        int                                    s;
        bit                                    br_used;
        logic [ID_WIDTH-1:0]                   sv;
        logic [ID_WIDTH-1:0][PRF_W-1:0]        phy;
        logic [ID_WIDTH-1:0][ARF_W-1:0]        arch;
        logic [CDB_WIDTH-1:0]                  cv;
        logic [CDB_WIDTH-1:0][ROB_ID_BITS-1:0] cid;

        for (s = 0; s < ID_WIDTH; s++) begin
            sv[s]   = ($urandom % 4) != 0;
            phy[s]  = PRF_W'($urandom);
            arch[s] = ARF_W'($urandom);
            if (s > 0 && ($urandom % 4) == 0) begin
                arch[s] = arch[0];  // same rd_arch twice in one row
            end
        end
        row_br_slot = -1;
        row_tgt     = $urandom & 32'hffff_fffc;
        if (($urandom % 3) == 0) begin
            for (s = ID_WIDTH - 1; s >= 0; s--) begin
                if (sv[s]) begin
                    row_br_slot = s;
                end
            end
        end
        row_mis = (row_br_slot >= 0) && (($urandom % 4) == 0);
        dispatch_valid      <= (rows_taken < N_ROWS) && (($urandom % 4) != 0);
        dispatch_slot_valid <= sv;
        dispatch_rd_phy     <= phy;
        dispatch_rd_arch    <= arch;

        for (i = 0; i < rows_q.size(); i++) begin
            for (s = 0; s < ID_WIDTH; s++) begin
                if (m_slot[rows_q[i]][s] && !m_sent[rows_q[i]][s]) begin
                    cands.push_back(rows_q[i] * ID_WIDTH + s);
                end
            end
        end
        cv      = '0;
        cid     = '0;
        br_used = 1'b0;
        br_valid <= 1'b0;
        for (k = 0; k < CDB_WIDTH; k++) begin
            if (cands.size() > 0 && ($urandom % 2) == 0) begin
                j  = int'($urandom % cands.size());
                id = cands[j];
                r  = id / ID_WIDTH;
                s  = id % ID_WIDTH;
                // one resolve port, so a second branch waits a cycle
                if (m_br_slot[r] != s || !br_used) begin
                    if (m_br_slot[r] == s) begin
                        br_used = 1'b1;
                        br_valid      <= 1'b1;
                        br_rob_id     <= ROB_ID_BITS'(id);
                        br_mispredict <= m_mis[r];
                        br_target     <= m_tgt[r];
                    end
                    cands.delete(j);
                    cv[k]        = 1'b1;
                    cid[k]       = ROB_ID_BITS'(id);
                    m_sent[r][s] = 1'b1;
                end
            end
        end
        cdb_valid      <= cv;
        cdb_rob_id     <= cid;
        redirect_ready <= ($urandom % 3) == 0;
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n               <= 1'b0;
        dispatch_valid      <= 1'b0;
        dispatch_slot_valid <= '0;
        dispatch_rd_phy     <= '0;
        dispatch_rd_arch    <= '0;
        cdb_valid           <= '0;
        cdb_rob_id          <= '0;
        br_valid            <= 1'b0;
        br_rob_id           <= '0;
        br_mispredict       <= 1'b0;
        br_target           <= '0;
        redirect_ready      <= 1'b0;
        m_tail      = 0;
        rows_taken  = 0;
        m_order     = '0;
        m_redir     = 1'b0;
        m_pc        = '0;
        row_br_slot = -1;
        row_mis     = 1'b0;
        row_tgt     = '0;
        for (int r = 0; r < ROB_DEPTH; r++) begin
            m_br_seen[r] = 1'b0;
        end
        for (int a = 0; a < 2**ARF_W; a++) begin
            m_map[a] = PRF_W'(a);  // identity after reset
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        while (rows_taken < N_ROWS || rows_q.size() > 0 || m_redir) begin
            @(negedge clk);
            model_edge();
            @(posedge clk);
            drive_inputs();
        end
        $display("TEST PASS");
        $finish;
    end

    //////////////////////////////
    // watchdog
    initial begin
        repeat (N_ROWS * 40 + 8) @(posedge clk);
        $display("timeout: the run did not drain within %0d cycles", N_ROWS * 40);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== rob_commit.f ====
design/backend_pkg.sv
design/backend_ifs.sv
design/rob.sv
design/branch_table.sv
design/retire_rat.sv
design/retire_counter.sv
design/redirect_fsm.sv
design/rob_commit_top.sv
verif/tb_rob_commit_properties.sv
verif/tb_rob_commit.sv

// ==== Makefile ====
# Verilator build and run for the rob_commit testbench

VERILATOR ?= verilator
TOP       ?= tb_rob_commit
FILELIST  ?= rob_commit.f
BUILD_DIR ?= build
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
